//--- dv/ring_tb.sv
`default_nettype none

module ring_tb
	import ring_bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic CLK_EXT;
	logic RESETn;
	logic [wd_width-1:0] threshold;
	logic [addr_width-1:0] h_tx_addr;
	logic [data_width-1:0] h_tx_data;
	logic h_tx_req;
	logic h_tx_ack;
	logic h_tx_succ;
	logic h_tx_fail;
	logic h_tx_resp_ack;
	logic [addr_width-1:0] h_rx_addr;
	logic [data_width-1:0] h_rx_data;
	logic h_rx_req;
	logic h_rx_ack;
	logic h_rx_fail;
	logic [addr_width-1:0] m_tx_addr;
	logic [data_width-1:0] m_tx_data;
	logic m_tx_req;
	logic m_tx_ack;
	logic m_tx_succ;
	logic m_tx_fail;
	logic m_tx_resp_ack;
	logic [addr_width-1:0] m_rx_addr;
	logic [data_width-1:0] m_rx_data;
	logic m_rx_req;
	logic m_rx_ack;
	logic m_rx_fail;

	// monitor state with one set per receiving port
	logic h_rx_req_q;
	logic h_rx_seen;
	logic h_rx_fail_seen;
	logic [addr_width-1:0] h_rx_addr_cap;
	logic [data_width-1:0] h_rx_data_cap;
	logic m_rx_req_q;
	logic m_rx_seen;
	logic m_rx_fail_seen;
	logic [addr_width-1:0] m_rx_addr_cap;
	logic [data_width-1:0] m_rx_data_cap;
	logic hold_host_rx;
	logic host_may_ack;

	// one finished transfer as seen by the ports and what it should have been
	string sender_name;
	string receiver_name;
	logic obs_succ;
	logic obs_fail;
	logic obs_rx;
	logic obs_rx_fail;
	logic [addr_width-1:0] obs_addr;
	logic [data_width-1:0] obs_data;
	logic [addr_width-1:0] sent_addr;
	logic [data_width-1:0] sent_data;
	logic [2:0] exp_outcome;
	event compare_now;

	logic [15:0] lfsr_state;
	int errors;
	int timeouts;
	int cycle_limit = 400;
	logic [data_width-1:0] word_a;
	logic [data_width-1:0] word_b;
	logic [1:0] pick;
	logic [addr_width-1:0] dest;
	bit waited;

	ring_top uut
	(
		.CLK_EXT(CLK_EXT),
		.RESETn(RESETn),
		.threshold(threshold),
		.h_tx_addr(h_tx_addr),
		.h_tx_data(h_tx_data),
		.h_tx_req(h_tx_req),
		.h_tx_ack(h_tx_ack),
		.h_tx_succ(h_tx_succ),
		.h_tx_fail(h_tx_fail),
		.h_tx_resp_ack(h_tx_resp_ack),
		.h_rx_addr(h_rx_addr),
		.h_rx_data(h_rx_data),
		.h_rx_req(h_rx_req),
		.h_rx_ack(h_rx_ack),
		.h_rx_fail(h_rx_fail),
		.m_tx_addr(m_tx_addr),
		.m_tx_data(m_tx_data),
		.m_tx_req(m_tx_req),
		.m_tx_ack(m_tx_ack),
		.m_tx_succ(m_tx_succ),
		.m_tx_fail(m_tx_fail),
		.m_tx_resp_ack(m_tx_resp_ack),
		.m_rx_addr(m_rx_addr),
		.m_rx_data(m_rx_data),
		.m_rx_req(m_rx_req),
		.m_rx_ack(m_rx_ack),
		.m_rx_fail(m_rx_fail)
	);

	always #5 CLK_EXT = ~CLK_EXT;

	// 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic [data_width-1:0] next_bits(input int n);
		logic [data_width-1:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = {lfsr_state[14:0],
				lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
			value = {value[data_width-2:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// result is {sender succeeds, receiver host sees rx_req, receiver pulses rx_fail}
	function automatic logic [2:0] expected_outcome(input bit from_member,
		input logic [addr_width-1:0] to_addr, input bit buffer_full, input bit wd_low);
		bit matched;
		bit hidden;
		if (from_member)
			matched = (to_addr == 8'haa) || (to_addr == ctrl_address);
		else
			matched = (to_addr == 8'h55);
		hidden = from_member && (to_addr == ctrl_address);
		// a member frame reaches the wrapper node only after the controller cut it
		if (!matched)
			return 3'b000;
		else if (wd_low && from_member)
			return 3'b001;
		else if (buffer_full)
			return 3'b000;
		else
			return {!wd_low, !hidden, 1'b0};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			errors++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// ports are sampled half a period away from the edge that updates them
	always @(negedge CLK_EXT)
	begin
		if (h_rx_req && !h_rx_req_q)
		begin
			h_rx_seen = 1'b1;
			h_rx_addr_cap = h_rx_addr;
			h_rx_data_cap = h_rx_data;
		end
		if (m_rx_req && !m_rx_req_q)
		begin
			m_rx_seen = 1'b1;
			m_rx_addr_cap = m_rx_addr;
			m_rx_data_cap = m_rx_data;
		end
		if (h_rx_fail)
			h_rx_fail_seen = 1'b1;
		if (m_rx_fail)
			m_rx_fail_seen = 1'b1;
		h_rx_req_q = h_rx_req;
		m_rx_req_q = m_rx_req;
	end

	// receive side hosts acknowledge every delivery unless the host is told to hold off
	always @(posedge CLK_EXT)
	begin
		host_may_ack = !hold_host_rx;
		#1;
		h_rx_ack = h_rx_req && host_may_ack;
		m_rx_ack = m_rx_req;
	end

	always @(compare_now)
	begin
		check_value({sender_name, "_tx_succ"}, 32'(obs_succ), 32'(exp_outcome[2]));
		check_value({sender_name, "_tx_fail"}, 32'(obs_fail), 32'(!exp_outcome[2]));
		check_value({receiver_name, "_rx_req"}, 32'(obs_rx), 32'(exp_outcome[1]));
		check_value({receiver_name, "_rx_fail"}, 32'(obs_rx_fail), 32'(exp_outcome[0]));
		if (exp_outcome[1] && obs_rx)
		begin
			check_value({receiver_name, "_rx_addr"}, 32'(obs_addr), 32'(sent_addr));
			check_value({receiver_name, "_rx_data"}, obs_data, sent_data);
		end
	end

	task automatic run_case(input bit from_member, input logic [addr_width-1:0] to_addr,
		input logic [data_width-1:0] data, input bit buffer_full);
		bit acked;
		bit done;
		acked = 1'b0;
		done = 1'b0;
		h_rx_seen = 1'b0;
		h_rx_fail_seen = 1'b0;
		m_rx_seen = 1'b0;
		m_rx_fail_seen = 1'b0;
		sender_name = from_member ? "m" : "h";
		receiver_name = from_member ? "h" : "m";
		if (from_member)
		begin
			m_tx_addr = to_addr;
			m_tx_data = data;
			m_tx_req = 1'b1;
		end
		else
		begin
			h_tx_addr = to_addr;
			h_tx_data = data;
			h_tx_req = 1'b1;
		end
		for (int i = 0; i < cycle_limit && !acked; i++)
		begin
			@(posedge CLK_EXT);
			#1;
			acked = from_member ? m_tx_ack : h_tx_ack;
		end
		m_tx_req = 1'b0;
		h_tx_req = 1'b0;
		if (!acked)
		begin
			timeouts++;
			$display("Timeout at %0t ns: %s_tx_ack never came", $time, sender_name);
			return;
		end
		for (int i = 0; i < cycle_limit && !done; i++)
		begin
			@(posedge CLK_EXT);
			#1;
			obs_succ = from_member ? m_tx_succ : h_tx_succ;
			obs_fail = from_member ? m_tx_fail : h_tx_fail;
			done = obs_succ || obs_fail;
		end
		if (!done)
		begin
			timeouts++;
			$display("Timeout at %0t ns: neither %s_tx_succ nor %s_tx_fail came",
				$time, sender_name, sender_name);
			return;
		end
		m_tx_resp_ack = from_member;
		h_tx_resp_ack = !from_member;
		@(posedge CLK_EXT);
		#1;
		m_tx_resp_ack = 1'b0;
		h_tx_resp_ack = 1'b0;
		repeat (3) @(posedge CLK_EXT);
		#1;
		obs_rx = from_member ? h_rx_seen : m_rx_seen;
		obs_rx_fail = from_member ? h_rx_fail_seen : m_rx_fail_seen;
		obs_addr = from_member ? h_rx_addr_cap : m_rx_addr_cap;
		obs_data = from_member ? h_rx_data_cap : m_rx_data_cap;
		sent_addr = to_addr;
		sent_data = data;
		exp_outcome = expected_outcome(from_member, to_addr, buffer_full, threshold < 60);
		-> compare_now;
		@(posedge CLK_EXT);
		#1;
	endtask

	initial
	begin
		CLK_EXT = 1'b0;
		RESETn = 1'b0;
		threshold = 10'd500;
		h_tx_addr = '0;
		h_tx_data = '0;
		h_tx_req = 1'b0;
		h_tx_resp_ack = 1'b0;
		h_rx_ack = 1'b0;
		m_tx_addr = '0;
		m_tx_data = '0;
		m_tx_req = 1'b0;
		m_tx_resp_ack = 1'b0;
		m_rx_ack = 1'b0;
		h_rx_req_q = 1'b0;
		m_rx_req_q = 1'b0;
		hold_host_rx = 1'b0;
		lfsr_state = 16'd19;
		errors = 0;
		timeouts = 0;
		repeat (4) @(posedge CLK_EXT);
		#1;
		RESETn = 1'b1;

		run_case(1'b0, 8'h55, next_bits(32), 1'b0);
		run_case(1'b1, 8'haa, next_bits(32), 1'b0);
		run_case(1'b1, ctrl_address, next_bits(32), 1'b0);

		// the second back-pressure frame meets a full buffer on the wrapper node
		hold_host_rx = 1'b1;
		word_a = next_bits(32);
		word_b = next_bits(32);
		run_case(1'b1, 8'haa, word_a, 1'b0);
		run_case(1'b1, 8'haa, word_b, 1'b1);
		check_value("h_rx_data", h_rx_data, word_a);
		hold_host_rx = 1'b0;
		waited = 1'b0;
		for (int i = 0; i < cycle_limit && !waited; i++)
		begin
			@(posedge CLK_EXT);
			#1;
			waited = !h_rx_req;
		end
		if (!waited)
		begin
			timeouts++;
			$display("Timeout at %0t ns: h_rx_req never fell after h_rx_ack", $time);
		end

		threshold = 10'd8;
		run_case(1'b1, 8'haa, next_bits(32), 1'b0);
		threshold = 10'd500;
		run_case(1'b1, 8'haa, next_bits(32), 1'b0);

		for (int n = 0; n < 20; n++)
		begin
			pick = 2'(next_bits(2));
			case (pick)
			2'd1: dest = ctrl_address;
			2'd2: dest = 8'(next_bits(8));
			default: dest = (n % 2 == 1) ? 8'haa : 8'h55;
			endcase
			run_case(n % 2 == 1, dest, next_bits(32), 1'b0);
		end

		repeat (4) @(posedge CLK_EXT);
		$display("Error count: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
hdl/ring_bus_pkg.sv
hdl/bus_ctrl.sv
hdl/bus_node.sv
hdl/ctrl_wrapper.sv
hdl/ring_top.sv
dv/ring_tb.sv

//--- hdl/bus_ctrl.sv
`default_nettype none

module bus_ctrl
	import ring_bus_pkg::*;
(
	input wire logic CLK_EXT,
	input wire logic RESETn,
	input wire logic din,
	output logic dout,
	input wire logic [wd_width-1:0] threshold
);

	typedef enum logic [2:0]
	{
		s_idle,
		s_token,
		s_wait,
		s_grant,
		s_frame
	} state_t;

	state_t state;
	logic [$clog2(idle_gap)-1:0] idle_cnt;
	logic [$clog2(token_bits)-1:0] tok_cnt;
	logic [wd_width-1:0] wd_cnt;

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			state <= s_idle;
			dout <= 1'b1;
			idle_cnt <= '0;
			tok_cnt <= '0;
			wd_cnt <= '0;
		end
		else
		begin
			case (state)
			s_idle:
			begin
				dout <= 1'b1;
				if (!din)
					idle_cnt <= '0;
				else if (idle_cnt == idle_gap - 1)
				begin
					idle_cnt <= '0;
					tok_cnt <= '0;
					state <= s_token;
				end
				else
					idle_cnt <= idle_cnt + 1'b1;
			end
			s_token:
			begin
				// start bit first, then a free grant bit
				dout <= (tok_cnt == token_bits - 1);
				tok_cnt <= tok_cnt + 1'b1;
				if (tok_cnt == token_bits - 1)
					state <= s_wait;
			end
			s_wait:
			begin
				dout <= din;
				if (!din)
					state <= s_grant;
			end
			s_grant:
			begin
				// a free token is killed by forcing its grant to 0 with no frame behind it
				dout <= 1'b0;
				if (din)
					state <= s_idle;
				else
				begin
					wd_cnt <= '0;
					state <= s_frame;
				end
			end
			s_frame:
			begin
				// the watchdog runs from the first frame bit and cuts the rest to ones
				if (wd_cnt > threshold)
					dout <= 1'b1;
				else
					dout <= din;
				wd_cnt <= wd_cnt + 1'b1;
				if (wd_cnt == slot_pos)
					state <= s_idle;
			end
			default:
			begin
				dout <= 1'b1;
				state <= s_idle;
			end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/bus_node.sv
`default_nettype none

module bus_node
	import ring_bus_pkg::*;
#(
	parameter logic [addr_width-1:0] address = 8'h00,
	parameter logic [addr_width-1:0] alt_address = 8'h00,
	parameter bit alt_en = 1'b0
)
(
	input wire logic CLK_EXT,
	input wire logic RESETn,
	input wire logic din,
	output logic dout,
	input wire logic [addr_width-1:0] tx_addr,
	input wire logic [data_width-1:0] tx_data,
	input wire logic tx_req,
	output logic tx_ack,
	output logic tx_succ,
	output logic tx_fail,
	input wire logic tx_resp_ack,
	output logic [addr_width-1:0] rx_addr,
	output logic [data_width-1:0] rx_data,
	output logic rx_req,
	input wire logic rx_ack,
	output logic rx_fail
);

	typedef enum logic [1:0]
	{
		r_idle,
		r_grant,
		r_frame
	} ring_state_t;

	ring_state_t rx_state;
	logic [pos_width-1:0] rx_pos;
	logic [payload_bits-1:0] rx_shift;
	logic rx_hold;
	logic [frame_bits-1:0] tx_frame;
	logic [pos_width-1:0] tx_pos;
	logic tx_sending;
	logic tx_waiting;
	logic ret_seen;
	logic mismatch;
	logic [to_width-1:0] to_cnt;

	logic claim;
	logic own_return;
	logic receiving;
	logic rx_match;
	logic rx_full;
	logic rx_load;

	assign claim = (rx_state == r_grant) && din && tx_req && !tx_ack && !tx_succ && !tx_fail
		&& !tx_sending && !tx_waiting;
	assign own_return = tx_sending || tx_waiting;
	assign receiving = (rx_state == r_frame) && !own_return;
	assign rx_match = (rx_shift[payload_bits-1 -: addr_width] == address)
		|| (alt_en && (rx_shift[payload_bits-1 -: addr_width] == alt_address));
	assign rx_full = rx_req || rx_ack;
	assign rx_load = receiving && (rx_pos == stop_pos) && rx_match && !din && !rx_full;

	// follows the ring stream, token header first and then the frame behind a claimed grant
	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			rx_state <= r_idle;
			rx_pos <= '0;
		end
		else
		begin
			case (rx_state)
			r_idle:
				if (!din)
					rx_state <= r_grant;
			r_grant:
			begin
				rx_pos <= '0;
				if (din)
					rx_state <= r_idle;
				else
					rx_state <= r_frame;
			end
			r_frame:
			begin
				rx_pos <= rx_pos + 1'b1;
				// no start bit behind the grant means a dead token
				if ((rx_pos == '0 && din) || rx_pos == slot_pos)
					rx_state <= r_idle;
			end
			default:
				rx_state <= r_idle;
			endcase
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (claim)
			tx_frame <= {1'b0, tx_addr, tx_data, 2'b01};
		if (receiving && rx_pos != '0 && rx_pos <= payload_bits)
			rx_shift <= {rx_shift[payload_bits-2:0], din};
		if (rx_load)
		begin
			rx_addr <= rx_shift[payload_bits-1 -: addr_width];
			rx_data <= rx_shift[data_width-1:0];
		end
	end

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
		begin
			dout <= 1'b1;
			tx_ack <= 1'b0;
			tx_succ <= 1'b0;
			tx_fail <= 1'b0;
			tx_pos <= '0;
			tx_sending <= 1'b0;
			tx_waiting <= 1'b0;
			ret_seen <= 1'b0;
			mismatch <= 1'b0;
			to_cnt <= '0;
			rx_req <= 1'b0;
			rx_fail <= 1'b0;
			rx_hold <= 1'b0;
		end
		else
		begin
			dout <= din;
			rx_fail <= 1'b0;

			if (claim)
				tx_ack <= 1'b1;
			else if (!tx_req)
				tx_ack <= 1'b0;

			if (tx_resp_ack)
			begin
				tx_succ <= 1'b0;
				tx_fail <= 1'b0;
			end

			if (claim)
			begin
				dout <= 1'b0;
				tx_sending <= 1'b1;
				tx_pos <= '0;
				ret_seen <= 1'b0;
				mismatch <= 1'b0;
			end
			else if (tx_sending)
			begin
				dout <= tx_frame[frame_bits-1-tx_pos];
				tx_pos <= tx_pos + 1'b1;
				if (tx_pos == slot_pos)
				begin
					tx_sending <= 1'b0;
					tx_waiting <= 1'b1;
					to_cnt <= '0;
				end
			end
			else if (tx_waiting)
			begin
				dout <= 1'b1;
				to_cnt <= to_cnt + 1'b1;
				if (!ret_seen && to_cnt == return_timeout - 1)
				begin
					tx_waiting <= 1'b0;
					tx_fail <= 1'b1;
				end
			end

			// our own frame coming back is compared bit by bit and judged at the slot
			if (rx_state == r_frame && own_return && (rx_pos != '0 || !din))
			begin
				if (rx_pos == '0)
					ret_seen <= 1'b1;
				if (rx_pos == slot_pos)
				begin
					tx_sending <= 1'b0;
					tx_waiting <= 1'b0;
					if (!mismatch && !din)
						tx_succ <= 1'b1;
					else
						tx_fail <= 1'b1;
				end
				else if (din != tx_frame[frame_bits-1-rx_pos])
					mismatch <= 1'b1;
			end

			if (rx_ack)
				rx_req <= 1'b0;

			if (receiving && rx_pos == stop_pos && rx_match)
			begin
				if (din)
					rx_fail <= 1'b1;
				else if (!rx_full)
				begin
					rx_req <= 1'b1;
					rx_hold <= 1'b1;
				end
			end

			// a full buffer leaves the slot at 1 and the frame is lost
			if (receiving && rx_pos == slot_pos && rx_hold)
			begin
				dout <= 1'b0;
				rx_hold <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/ctrl_wrapper.sv
`default_nettype none

module ctrl_wrapper
	import ring_bus_pkg::*;
#(
	parameter logic [addr_width-1:0] node_address = 8'haa
)
(
	input wire logic CLK_EXT,
	input wire logic RESETn,
	input wire logic ring_in,
	output wire logic ring_out,
	input wire logic [addr_width-1:0] tx_addr,
	input wire logic [data_width-1:0] tx_data,
	input wire logic tx_req,
	output wire logic tx_ack,
	output wire logic tx_succ,
	output wire logic tx_fail,
	input wire logic tx_resp_ack,
	output wire logic [addr_width-1:0] rx_addr,
	output wire logic [data_width-1:0] rx_data,
	output wire logic rx_req,
	input wire logic rx_ack,
	output wire logic rx_fail,
	input wire logic [wd_width-1:0] threshold
);

	logic ctrl_to_node;
	logic node_rx_req;
	logic node_rx_ack;
	logic ctrl_addr_match;
	logic ctrl_rx_ack;

	// frames for the controller are taken here and never reach the host
	assign ctrl_addr_match = (rx_addr == ctrl_address);
	assign rx_req = ctrl_addr_match ? 1'b0 : node_rx_req;
	assign node_rx_ack = rx_ack | ctrl_rx_ack;

	always_ff @(posedge CLK_EXT or negedge RESETn)
	begin
		if (!RESETn)
			ctrl_rx_ack <= 1'b0;
		else if (ctrl_addr_match && node_rx_req)
			ctrl_rx_ack <= 1'b1;
		else if (!node_rx_req)
			ctrl_rx_ack <= 1'b0;
	end

	bus_ctrl ctrl0
	(
		.CLK_EXT(CLK_EXT),
		.RESETn(RESETn),
		.din(ring_in),
		.dout(ctrl_to_node),
		.threshold(threshold)
	);

	bus_node #(.address(node_address), .alt_address(ctrl_address), .alt_en(1'b1)) node0
	(
		.CLK_EXT(CLK_EXT),
		.RESETn(RESETn),
		.din(ctrl_to_node),
		.dout(ring_out),
		.tx_addr(tx_addr),
		.tx_data(tx_data),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.tx_succ(tx_succ),
		.tx_fail(tx_fail),
		.tx_resp_ack(tx_resp_ack),
		.rx_addr(rx_addr),
		.rx_data(rx_data),
		.rx_req(node_rx_req),
		.rx_ack(node_rx_ack),
		.rx_fail(rx_fail)
	);

endmodule

`default_nettype wire

//--- hdl/ring_bus_pkg.sv
`default_nettype none

package ring_bus_pkg;

	localparam int addr_width = 8;
	localparam int data_width = 32;

	// a frame is start, address, data, stop and the acknowledge slot
	localparam int payload_bits = addr_width + data_width;
	localparam int frame_bits = payload_bits + 3;
	localparam int stop_pos = frame_bits - 2;
	localparam int slot_pos = frame_bits - 1;
	localparam int pos_width = $clog2(frame_bits);

	// a token is a start bit and then a grant bit that stays 1 while the token is free
	localparam int token_bits = 2;

	localparam int idle_gap = 4;
	localparam int return_timeout = 96;
	localparam int to_width = $clog2(return_timeout + 1);

	localparam int wd_width = 10;

	localparam logic [addr_width-1:0] ctrl_address = 8'h01;

endpackage

`default_nettype wire

//--- hdl/ring_top.sv
`default_nettype none

module ring_top
	import ring_bus_pkg::*;
(
	input wire logic CLK_EXT,
	input wire logic RESETn,
	input wire logic [wd_width-1:0] threshold,
	input wire logic [addr_width-1:0] h_tx_addr,
	input wire logic [data_width-1:0] h_tx_data,
	input wire logic h_tx_req,
	output wire logic h_tx_ack,
	output wire logic h_tx_succ,
	output wire logic h_tx_fail,
	input wire logic h_tx_resp_ack,
	output wire logic [addr_width-1:0] h_rx_addr,
	output wire logic [data_width-1:0] h_rx_data,
	output wire logic h_rx_req,
	input wire logic h_rx_ack,
	output wire logic h_rx_fail,
	input wire logic [addr_width-1:0] m_tx_addr,
	input wire logic [data_width-1:0] m_tx_data,
	input wire logic m_tx_req,
	output wire logic m_tx_ack,
	output wire logic m_tx_succ,
	output wire logic m_tx_fail,
	input wire logic m_tx_resp_ack,
	output wire logic [addr_width-1:0] m_rx_addr,
	output wire logic [data_width-1:0] m_rx_data,
	output wire logic m_rx_req,
	input wire logic m_rx_ack,
	output wire logic m_rx_fail
);

	// ring order is controller, wrapper node, member, back to controller
	logic ring_w2m;
	logic ring_m2w;

	ctrl_wrapper #(.node_address(8'haa)) wrap0
	(
		.CLK_EXT(CLK_EXT),
		.RESETn(RESETn),
		.ring_in(ring_m2w),
		.ring_out(ring_w2m),
		.tx_addr(h_tx_addr),
		.tx_data(h_tx_data),
		.tx_req(h_tx_req),
		.tx_ack(h_tx_ack),
		.tx_succ(h_tx_succ),
		.tx_fail(h_tx_fail),
		.tx_resp_ack(h_tx_resp_ack),
		.rx_addr(h_rx_addr),
		.rx_data(h_rx_data),
		.rx_req(h_rx_req),
		.rx_ack(h_rx_ack),
		.rx_fail(h_rx_fail),
		.threshold(threshold)
	);

	bus_node #(.address(8'h55), .alt_en(1'b0)) member
	(
		.CLK_EXT(CLK_EXT),
		.RESETn(RESETn),
		.din(ring_w2m),
		.dout(ring_m2w),
		.tx_addr(m_tx_addr),
		.tx_data(m_tx_data),
		.tx_req(m_tx_req),
		.tx_ack(m_tx_ack),
		.tx_succ(m_tx_succ),
		.tx_fail(m_tx_fail),
		.tx_resp_ack(m_tx_resp_ack),
		.rx_addr(m_rx_addr),
		.rx_data(m_rx_data),
		.rx_req(m_rx_req),
		.rx_ack(m_rx_ack),
		.rx_fail(m_rx_fail)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds and runs the ring bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ring_tb -f files.f -o ring_sim

output=$(./obj_dir/ring_sim)
echo "$output"

if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1
